/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_id_stage -f src.f --Mdir obj_dir -o tb_id_stage
	./obj_dir/tb_id_stage

clean:
	rm -rf obj_dir

/* common/id_cfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath widths
`define REG_W      32
`define REG_ADDR_W 5
`define INST_W     32

// register zero, used for idle addresses
`define NOP_REG_ADDR 5'b00000

`endif

/* common/id_ctrl_if.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

interface id_ctrl_if import mips_id_pkg::*; ();

    aluop_e                 aluop;
    alusel_e                alusel;
    logic                   reg1_read;
    logic                   reg2_read;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic [`REG_ADDR_W-1:0] wd;        // destination register
    logic                   wreg;
    logic [`REG_W-1:0]      imm;       // already extended

    modport dec (
        output aluop, alusel, reg1_read, reg2_read,
        output reg1_addr, reg2_addr, wd, wreg, imm
    );

    modport sel (
        input aluop, alusel, reg1_read, reg2_read,
        input reg1_addr, reg2_addr, wd, wreg, imm
    );

endinterface

/* common/id_ex_if.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

interface id_ex_if import mips_id_pkg::*; ();

    aluop_e                 aluop;
    alusel_e                alusel;
    logic [`REG_W-1:0]      reg1;   // resolved source operands
    logic [`REG_W-1:0]      reg2;
    logic [`REG_ADDR_W-1:0] wd;
    logic                   wreg;

    modport src (
        output aluop, alusel, reg1, reg2, wd, wreg
    );

    modport dst (
        input aluop, alusel, reg1, reg2, wd, wreg
    );

endinterface

/* common/mips_id_pkg.sv */
package mips_id_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } aluop_e;

    // result class picked in execute
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

/* decode/inst_decoder.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module inst_decoder import mips_id_pkg::*; (
    input  logic               rst_i,
    input  logic [`INST_W-1:0] inst_i,
    id_ctrl_if.dec             ctrl
);

    opcode_e                op;
    funct_e                 fn;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] sa;
    logic [15:0]            imm16;

    logic              const_shift;
    aluop_e            rr_aluop;
    alusel_e           rr_alusel;
    aluop_e            im_aluop;
    alusel_e           im_alusel;
    logic [`REG_W-1:0] im_ext;

    assign op    = opcode_e'(inst_i[31:26]);
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign fn    = funct_e'(inst_i[5:0]);
    assign imm16 = inst_i[15:0];

    // shift amount taken from the sa field
    assign const_shift = (fn inside {FN_SLL, FN_SRL, FN_SRA});

    always_comb begin
        case (fn)
            FN_OR:           rr_aluop = ALU_OR;
            FN_AND:          rr_aluop = ALU_AND;
            FN_XOR:          rr_aluop = ALU_XOR;
            FN_NOR:          rr_aluop = ALU_NOR;
            FN_SLLV, FN_SLL: rr_aluop = ALU_SLL;
            FN_SRLV, FN_SRL: rr_aluop = ALU_SRL;
            FN_SRAV, FN_SRA: rr_aluop = ALU_SRA;
            FN_SLT:          rr_aluop = ALU_SLT;
            FN_SLTU:         rr_aluop = ALU_SLTU;
            FN_ADD:          rr_aluop = ALU_ADD;
            FN_ADDU:         rr_aluop = ALU_ADDU;
            FN_SUB:          rr_aluop = ALU_SUB;
            FN_SUBU:         rr_aluop = ALU_SUBU;
            default:         rr_aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        case (fn)
            FN_OR, FN_AND, FN_XOR, FN_NOR:
                rr_alusel = SEL_LOGIC;
            FN_SLLV, FN_SRLV, FN_SRAV, FN_SLL, FN_SRL, FN_SRA:
                rr_alusel = SEL_SHIFT;
            FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU:
                rr_alusel = SEL_ARITH;
            default:
                rr_alusel = SEL_NOP;
        endcase
    end

    // immediate forms
    always_comb begin
        case (op)
            OP_ORI, OP_LUI: im_aluop = ALU_OR;   // lui is or with upper imm
            OP_ANDI:        im_aluop = ALU_AND;
            OP_XORI:        im_aluop = ALU_XOR;
            OP_SLTI:        im_aluop = ALU_SLT;
            OP_SLTIU:       im_aluop = ALU_SLTU;
            OP_ADDI:        im_aluop = ALU_ADDI;
            OP_ADDIU:       im_aluop = ALU_ADDIU;
            default:        im_aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI:
                im_alusel = SEL_LOGIC;
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU:
                im_alusel = SEL_ARITH;
            default:
                im_alusel = SEL_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_ORI, OP_ANDI, OP_XORI: im_ext = {{(`REG_W-16){1'b0}}, imm16};
            OP_LUI:                   im_ext = {imm16, {(`REG_W-16){1'b0}}};
            default:                  im_ext = {{(`REG_W-16){imm16[15]}}, imm16};
        endcase
    end

    always_comb begin
        ctrl.aluop     = ALU_NOP;
        ctrl.alusel    = SEL_NOP;
        ctrl.reg1_read = 1'b0;
        ctrl.reg2_read = 1'b0;
        ctrl.reg1_addr = rs;
        ctrl.reg2_addr = rt;
        ctrl.wd        = rd;
        ctrl.wreg      = 1'b0;
        ctrl.imm       = '0;
        if (rst_i) begin
            ctrl.reg1_addr = `NOP_REG_ADDR;
            ctrl.reg2_addr = `NOP_REG_ADDR;
            ctrl.wd        = `NOP_REG_ADDR;
        end else if (op == OP_SPECIAL) begin
            if (const_shift) begin
                // opcode already zero, so rs zero covers the top eleven bits
                if (rs == '0) begin
                    ctrl.aluop     = rr_aluop;
                    ctrl.alusel    = rr_alusel;
                    ctrl.reg2_read = 1'b1;
                    ctrl.wreg      = 1'b1;
                    ctrl.imm       = {{(`REG_W-`REG_ADDR_W){1'b0}}, sa};
                end
            end else if (sa == '0 && rr_alusel != SEL_NOP) begin
                ctrl.aluop     = rr_aluop;
                ctrl.alusel    = rr_alusel;
                ctrl.reg1_read = 1'b1;
                ctrl.reg2_read = 1'b1;
                ctrl.wreg      = 1'b1;
            end
        end else if (im_alusel != SEL_NOP) begin
            ctrl.aluop     = im_aluop;
            ctrl.alusel    = im_alusel;
            ctrl.reg1_read = 1'b1;
            ctrl.wreg      = 1'b1;
            ctrl.wd        = rt;                  // i-type writes rt
            ctrl.imm       = im_ext;
        end
    end

endmodule

/* decode/operand_mux.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module operand_mux import mips_id_pkg::*; (
    input  logic                   rst_i,
    id_ctrl_if.sel                 ctrl,
    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  logic [`REG_W-1:0]      ex_wdata_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wd_i,
    input  logic [`REG_W-1:0]      mem_wdata_i,
    input  logic [`REG_W-1:0]      reg1_data_i,
    input  logic [`REG_W-1:0]      reg2_data_i,
    id_ex_if.src                   ex
);

    // execute result beats memory result beats register file
    function automatic logic [`REG_W-1:0] resolve(
        input logic                   rd_en,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`REG_W-1:0]      rf_data,
        input logic [`REG_W-1:0]      imm
    );
        if (!rd_en) begin
            return imm;
        end else if (ex_wreg_i && ex_wd_i == addr) begin
            return ex_wdata_i;
        end else if (mem_wreg_i && mem_wd_i == addr) begin
            return mem_wdata_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        if (rst_i) begin
            ex.reg1 = '0;
            ex.reg2 = '0;
        end else begin
            ex.reg1 = resolve(ctrl.reg1_read, ctrl.reg1_addr, reg1_data_i, ctrl.imm);
            ex.reg2 = resolve(ctrl.reg2_read, ctrl.reg2_addr, reg2_data_i, ctrl.imm);
        end
    end

    assign ex.aluop  = ctrl.aluop;
    assign ex.alusel = ctrl.alusel;
    assign ex.wd     = ctrl.wd;
    assign ex.wreg   = ctrl.wreg;

endmodule

/* rtl/id_ex.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_ex import mips_id_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    id_ex_if.dst                   ex,
    output aluop_e                 ex_aluop_o,
    output alusel_e                ex_alusel_o,
    output logic [`REG_W-1:0]      ex_reg1_o,
    output logic [`REG_W-1:0]      ex_reg2_o,
    output logic [`REG_ADDR_W-1:0] ex_wd_o,
    output logic                   ex_wreg_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // bubble into execute
            ex_aluop_o  <= ALU_NOP;
            ex_alusel_o <= SEL_NOP;
            ex_reg1_o   <= '0;
            ex_reg2_o   <= '0;
            ex_wd_o     <= `NOP_REG_ADDR;
            ex_wreg_o   <= 1'b0;
        end else begin
            ex_aluop_o  <= ex.aluop;
            ex_alusel_o <= ex.alusel;
            ex_reg1_o   <= ex.reg1;
            ex_reg2_o   <= ex.reg2;
            ex_wd_o     <= ex.wd;
            ex_wreg_o   <= ex.wreg;
        end
    end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_stage import mips_id_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`INST_W-1:0]     inst_i,

    // register file read data, same cycle
    input  logic [`REG_W-1:0]      reg1_data_i,
    input  logic [`REG_W-1:0]      reg2_data_i,

    input  logic                   ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0] ex_wd_i,
    input  logic [`REG_W-1:0]      ex_wdata_i,
    input  logic                   mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0] mem_wd_i,
    input  logic [`REG_W-1:0]      mem_wdata_i,

    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,

    output aluop_e                 ex_aluop_o,
    output alusel_e                ex_alusel_o,
    output logic [`REG_W-1:0]      ex_reg1_o,
    output logic [`REG_W-1:0]      ex_reg2_o,
    output logic [`REG_ADDR_W-1:0] ex_wd_o,
    output logic                   ex_wreg_o
);

    id_ctrl_if ctrl_if ();
    id_ex_if   ex_if ();

    inst_decoder i_inst_decoder (
        .rst_i  (rst_i),
        .inst_i (inst_i),
        .ctrl   (ctrl_if)
    );

    operand_mux i_operand_mux (
        .rst_i       (rst_i),
        .ctrl        (ctrl_if),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex          (ex_if)
    );

    id_ex i_id_ex (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex          (ex_if),
        .ex_aluop_o  (ex_aluop_o),
        .ex_alusel_o (ex_alusel_o),
        .ex_reg1_o   (ex_reg1_o),
        .ex_reg2_o   (ex_reg2_o),
        .ex_wd_o     (ex_wd_o),
        .ex_wreg_o   (ex_wreg_o)
    );

    // read port requests straight from decode
    assign reg1_read_o = ctrl_if.reg1_read;
    assign reg2_read_o = ctrl_if.reg2_read;
    assign reg1_addr_o = ctrl_if.reg1_addr;
    assign reg2_addr_o = ctrl_if.reg2_addr;

endmodule

/* src.f */
+incdir+common
common/mips_id_pkg.sv
common/id_ctrl_if.sv
common/id_ex_if.sv
decode/inst_decoder.sv
decode/operand_mux.sv
rtl/id_ex.sv
rtl/id_stage.sv
testbench/id_stage_assertions.sv
testbench/tb_id_stage.sv

/* testbench/id_stage_assertions.sv */
`timescale 1ns/1ps

module id_stage_assertions import mips_id_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input logic    reg1_read_o,
    input logic    reg2_read_o,
    input aluop_e  ex_aluop_o,
    input alusel_e ex_alusel_o,
    input logic    ex_wreg_o
);

    // a reset cycle always leaves a bubble
    a_reset_bubble: assert property (@(posedge clk) rst_i |=> !ex_wreg_o)
        else $error("ex_wreg_o high in the cycle after reset");

    a_nop_pair: assert property (@(posedge clk) disable iff (rst_i)
        (ex_aluop_o == ALU_NOP) == (ex_alusel_o == SEL_NOP))
        else $error("ex_aluop_o and ex_alusel_o disagree about nop");

    a_wreg_has_op: assert property (@(posedge clk) disable iff (rst_i)
        ex_wreg_o |-> ex_aluop_o != ALU_NOP)
        else $error("register write issued with a nop operation");

    a_reads_known: assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown({reg1_read_o, reg2_read_o}))
        else $error("read enable unknown");

endmodule

bind id_stage id_stage_assertions i_id_stage_assertions (.*);

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module tb_id_stage import mips_id_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int TEST_CYCLES = 50;   // 3 reset + 43 decodes, rounded up
    localparam int EXT_ZERO    = 0;
    localparam int EXT_SIGN    = 1;
    localparam int EXT_UPPER   = 2;
    localparam int SRC_RF      = 0;
    localparam int SRC_MEM     = 1;
    localparam int SRC_EX      = 2;

    logic                   clk;
    logic                   rst_i;
    logic [`INST_W-1:0]     inst_i;
    logic [`REG_W-1:0]      reg1_data_i;
    logic [`REG_W-1:0]      reg2_data_i;
    logic                   ex_wreg_i;
    logic [`REG_ADDR_W-1:0] ex_wd_i;
    logic [`REG_W-1:0]      ex_wdata_i;
    logic                   mem_wreg_i;
    logic [`REG_ADDR_W-1:0] mem_wd_i;
    logic [`REG_W-1:0]      mem_wdata_i;
    logic                   reg1_read_o;
    logic                   reg2_read_o;
    logic [`REG_ADDR_W-1:0] reg1_addr_o;
    logic [`REG_ADDR_W-1:0] reg2_addr_o;
    aluop_e                 ex_aluop_o;
    alusel_e                ex_alusel_o;
    logic [`REG_W-1:0]      ex_reg1_o;
    logic [`REG_W-1:0]      ex_reg2_o;
    logic [`REG_ADDR_W-1:0] ex_wd_o;
    logic                   ex_wreg_o;
    logic [31:0]            lfsr_q;

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 200);
        abort_run("timeout: the directed tests did not complete in time");
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[31]};
        end
        return r;
    endfunction

    function automatic logic [`INST_W-1:0] encode_r_type(input funct_e fn,
            input logic [`REG_ADDR_W-1:0] rs, rt, rd, sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [`REG_W-1:0] extend(input int kind, input logic [15:0] imm);
        case (kind)
            EXT_ZERO: return {16'h0000, imm};
            EXT_SIGN: return {{16{imm[15]}}, imm};
            default:  return {imm, 16'h0000};
        endcase
    endfunction

    task automatic check_aluop(input string name, input aluop_e want, input aluop_e got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] time %0t %s expected %s actual %s (%h)",
                                $time, name, want.name(), got.name(), got));
        end
    endtask

    task automatic check_alusel(input string name, input alusel_e want, input alusel_e got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] time %0t %s expected %s actual %s (%h)",
                                $time, name, want.name(), got.name(), got));
        end
    endtask

    task automatic check_word(input string name, input logic [`REG_W-1:0] want, got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] time %0t %s expected %h actual %h",
                                $time, name, want, got));
        end
    endtask

    task automatic check_addr(input string name, input logic [`REG_ADDR_W-1:0] want, got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] time %0t %s expected %0d actual %0d",
                                $time, name, want, got));
        end
    endtask

    task automatic check_bit(input string name, input logic want, got);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] time %0t %s expected %b actual %b",
                                $time, name, want, got));
        end
    endtask

    task automatic check_ex_outputs(input aluop_e op, input alusel_e sel,
                                    input logic [`REG_W-1:0] r1, r2,
                                    input logic [`REG_ADDR_W-1:0] wd, input logic wreg);
        check_aluop("ex_aluop_o", op, ex_aluop_o);
        check_alusel("ex_alusel_o", sel, ex_alusel_o);
        check_word("ex_reg1_o", r1, ex_reg1_o);
        check_word("ex_reg2_o", r2, ex_reg2_o);
        check_addr("ex_wd_o", wd, ex_wd_o);
        check_bit("ex_wreg_o", wreg, ex_wreg_o);
    endtask

    // called 1 ns after an edge, leaves 1 ns for decode to settle
    task automatic drive(input logic [`INST_W-1:0] inst, input logic [`REG_W-1:0] d1, d2);
        inst_i      = inst;
        reg1_data_i = d1;
        reg2_data_i = d2;
        #1;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        drive(encode_r_type(FN_ADD, 5'd3, 5'd4, 5'd5, 5'd0), 32'h1111_2222, 32'h3333_4444);
        repeat (3) begin
            check_bit("reg1_read_o", 1'b0, reg1_read_o);
            check_bit("reg2_read_o", 1'b0, reg2_read_o);
            check_addr("reg1_addr_o", `NOP_REG_ADDR, reg1_addr_o);
            check_addr("reg2_addr_o", `NOP_REG_ADDR, reg2_addr_o);
            next_edge();
            check_ex_outputs(ALU_NOP, SEL_NOP, '0, '0, `NOP_REG_ADDR, 1'b0);
        end
        rst_i = 1'b0;
    endtask

    task automatic test_reg_form(input funct_e fn, input aluop_e op, input alusel_e sel);
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_W-1:0]      d1;
        logic [`REG_W-1:0]      d2;
        rs = 5'(take_bits(5));
        rt = 5'(take_bits(5));
        rd = 5'(take_bits(5));
        d1 = take_bits(32);
        d2 = take_bits(32);
        drive(encode_r_type(fn, rs, rt, rd, 5'd0), d1, d2);
        check_bit("reg1_read_o", 1'b1, reg1_read_o);
        check_bit("reg2_read_o", 1'b1, reg2_read_o);
        check_addr("reg1_addr_o", rs, reg1_addr_o);
        check_addr("reg2_addr_o", rt, reg2_addr_o);
        next_edge();
        check_ex_outputs(op, sel, d1, d2, rd, 1'b1);
    endtask

    task automatic test_imm_form(input opcode_e opc, input aluop_e op,
                                 input alusel_e sel, input int kind);
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
        logic [`REG_W-1:0]      d1;
        for (int k = 0; k < 2; k++) begin
            rs      = 5'(take_bits(5));
            rt      = 5'(take_bits(5));
            imm     = 16'(take_bits(16));
            imm[15] = (k == 0);    // one negative, one positive
            d1      = take_bits(32);
            drive({opc, rs, rt, imm}, d1, take_bits(32));
            check_bit("reg1_read_o", 1'b1, reg1_read_o);
            check_bit("reg2_read_o", 1'b0, reg2_read_o);
            check_addr("reg1_addr_o", rs, reg1_addr_o);
            next_edge();
            check_ex_outputs(op, sel, d1, extend(kind, imm), rt, 1'b1);
        end
    endtask

    task automatic test_const_shift(input funct_e fn, input aluop_e op);
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] sa;
        logic [`REG_W-1:0]      d2;
        rt = 5'(take_bits(5));
        rd = 5'(take_bits(5));
        sa = 5'(take_bits(5));
        d2 = take_bits(32);
        drive(encode_r_type(fn, 5'd0, rt, rd, sa), take_bits(32), d2);
        check_bit("reg1_read_o", 1'b0, reg1_read_o);
        check_bit("reg2_read_o", 1'b1, reg2_read_o);
        check_addr("reg2_addr_o", rt, reg2_addr_o);
        next_edge();
        check_ex_outputs(op, SEL_SHIFT, {{(`REG_W-`REG_ADDR_W){1'b0}}, sa}, d2, rd, 1'b1);
    endtask

    // memory stage always targets the port under test
    task automatic forward_case(input logic second, input logic ew, input logic mw,
                                input logic ex_hit, input int src);
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] hit;
        logic [`REG_W-1:0]      d1;
        logic [`REG_W-1:0]      d2;
        logic [`REG_W-1:0]      want;
        rs          = 5'(take_bits(5));
        rt          = rs + 5'd1;
        hit         = second ? rt : rs;
        d1          = take_bits(32);
        d2          = take_bits(32);
        ex_wreg_i   = ew;
        ex_wd_i     = ex_hit ? hit : rs + 5'd2;   // rs + 2 matches neither port
        mem_wreg_i  = mw;
        mem_wd_i    = hit;
        ex_wdata_i  = take_bits(32);
        mem_wdata_i = take_bits(32);
        drive(encode_r_type(FN_ADDU, rs, rt, 5'(take_bits(5)), 5'd0), d1, d2);
        case (src)
            SRC_EX:  want = ex_wdata_i;
            SRC_MEM: want = mem_wdata_i;
            default: want = second ? d2 : d1;
        endcase
        next_edge();
        if (second) begin
            check_word("ex_reg2_o", want, ex_reg2_o);
            check_word("ex_reg1_o", d1, ex_reg1_o);
        end else begin
            check_word("ex_reg1_o", want, ex_reg1_o);
            check_word("ex_reg2_o", d2, ex_reg2_o);
        end
    endtask

    task automatic test_unknown(input logic [`INST_W-1:0] inst);
        drive(inst, take_bits(32), take_bits(32));
        check_bit("reg1_read_o", 1'b0, reg1_read_o);
        check_bit("reg2_read_o", 1'b0, reg2_read_o);
        next_edge();
        check_ex_outputs(ALU_NOP, SEL_NOP, '0, '0, inst[15:11], 1'b0);
    endtask

    initial begin
        lfsr_q      = 32'h3122;
        rst_i       = 1'b1;
        inst_i      = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;

        test_reset();

        test_reg_form(FN_OR, ALU_OR, SEL_LOGIC);
        test_reg_form(FN_AND, ALU_AND, SEL_LOGIC);
        test_reg_form(FN_XOR, ALU_XOR, SEL_LOGIC);
        test_reg_form(FN_NOR, ALU_NOR, SEL_LOGIC);
        test_reg_form(FN_SLLV, ALU_SLL, SEL_SHIFT);
        test_reg_form(FN_SRLV, ALU_SRL, SEL_SHIFT);
        test_reg_form(FN_SRAV, ALU_SRA, SEL_SHIFT);
        test_reg_form(FN_SLT, ALU_SLT, SEL_ARITH);
        test_reg_form(FN_SLTU, ALU_SLTU, SEL_ARITH);
        test_reg_form(FN_ADD, ALU_ADD, SEL_ARITH);
        test_reg_form(FN_ADDU, ALU_ADDU, SEL_ARITH);
        test_reg_form(FN_SUB, ALU_SUB, SEL_ARITH);
        test_reg_form(FN_SUBU, ALU_SUBU, SEL_ARITH);

        test_imm_form(OP_ORI, ALU_OR, SEL_LOGIC, EXT_ZERO);
        test_imm_form(OP_ANDI, ALU_AND, SEL_LOGIC, EXT_ZERO);
        test_imm_form(OP_XORI, ALU_XOR, SEL_LOGIC, EXT_ZERO);
        test_imm_form(OP_LUI, ALU_OR, SEL_LOGIC, EXT_UPPER);
        test_imm_form(OP_SLTI, ALU_SLT, SEL_ARITH, EXT_SIGN);
        test_imm_form(OP_SLTIU, ALU_SLTU, SEL_ARITH, EXT_SIGN);
        test_imm_form(OP_ADDI, ALU_ADDI, SEL_ARITH, EXT_SIGN);
        test_imm_form(OP_ADDIU, ALU_ADDIU, SEL_ARITH, EXT_SIGN);

        test_const_shift(FN_SLL, ALU_SLL);
        test_const_shift(FN_SRL, ALU_SRL);
        test_const_shift(FN_SRA, ALU_SRA);

        for (int p = 0; p < 2; p++) begin
            forward_case(1'(p), 1'b1, 1'b1, 1'b1, SRC_EX);
            forward_case(1'(p), 1'b1, 1'b1, 1'b0, SRC_MEM);
            forward_case(1'(p), 1'b0, 1'b1, 1'b1, SRC_MEM);
            forward_case(1'(p), 1'b0, 1'b0, 1'b1, SRC_RF);
        end
        ex_wreg_i  = 1'b0;
        mem_wreg_i = 1'b0;

        test_unknown({6'b100011, 5'd4, 5'd9, 16'h0010});               // lw opcode
        test_unknown(encode_r_type(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd7));    // sa not zero
        test_unknown({OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b001000});  // jr funct

        $display("Done: no errors");
        $finish;
    end

endmodule
